// ==== riscv_em_dmem.sv ====
module riscv_em_dmem
(
    input  logic                    i_riscv_em_clk,
    input  logic                    i_riscv_em_memwe,
    input  riscv_em_pkg::byte_en_t  i_riscv_em_byte_en,
    input  riscv_em_pkg::dmem_idx_t i_riscv_em_idx,
    input  riscv_em_pkg::dword_t    i_riscv_em_wdata,
    output riscv_em_pkg::dword_t    o_riscv_em_rdata
);

    import riscv_em_pkg::*;

    dword_t mem [DMEM_DEPTH];               // Doubleword storage, contents survive reset.

    // Each enabled lane is written on its own; other lanes keep their bytes.
    always_ff @(posedge i_riscv_em_clk)
    begin : dmem_write_proc
        if (i_riscv_em_memwe)
        begin
            for (int lane = 0; lane < 8; lane++)
            begin
                if (i_riscv_em_byte_en[lane])
                begin
                    mem[i_riscv_em_idx][lane*8 +: 8] <= i_riscv_em_wdata[lane*8 +: 8];
                end
            end
        end
    end

    // Read is asynchronous so the load result is ready in the same cycle.
    assign o_riscv_em_rdata = mem[i_riscv_em_idx];

endmodule

// ==== riscv_em_load_ext.sv ====
module riscv_em_load_ext
(
    input  riscv_em_pkg::dword_t     i_riscv_em_rdata,
    input  riscv_em_pkg::dword_t     i_riscv_em_addr_m,
    input  riscv_em_pkg::dword_t     i_riscv_em_pcplus4_m,
    input  riscv_em_pkg::dword_t     i_riscv_em_imm_m,
    input  riscv_em_pkg::memext_t    i_riscv_em_memext_m,
    input  riscv_em_pkg::resultsrc_t i_riscv_em_resultsrc_m,
    output riscv_em_pkg::dword_t     o_riscv_em_wbdata
);

    import riscv_em_pkg::*;

    dword_t shifted;                        // Read data with the addressed byte in lane 0.
    dword_t load_val;                       // Extended load result.

    assign shifted = i_riscv_em_rdata >> {i_riscv_em_addr_m[2:0], 3'b000};

    always_comb
    begin
        case (i_riscv_em_memext_m)
            LOAD_B:  load_val = {{56{shifted[7]}}, shifted[7:0]};
            LOAD_H:  load_val = {{48{shifted[15]}}, shifted[15:0]};
            LOAD_W:  load_val = {{32{shifted[31]}}, shifted[31:0]};
            LOAD_D:  load_val = shifted;
            LOAD_BU: load_val = {56'd0, shifted[7:0]};
            LOAD_HU: load_val = {48'd0, shifted[15:0]};
            LOAD_WU: load_val = {32'd0, shifted[31:0]};
            default: load_val = shifted;             // Code 7 is not a valid load.
        endcase
    end

    // Writeback value for the later stages.
    always_comb
    begin
        case (i_riscv_em_resultsrc_m)
            RESULT_ALU:     o_riscv_em_wbdata = i_riscv_em_addr_m;
            RESULT_LOAD:    o_riscv_em_wbdata = load_val;
            RESULT_PCPLUS4: o_riscv_em_wbdata = i_riscv_em_pcplus4_m;
            RESULT_IMM:     o_riscv_em_wbdata = i_riscv_em_imm_m;
            default:        o_riscv_em_wbdata = i_riscv_em_addr_m;
        endcase
    end

endmodule

// ==== riscv_em_mem_stage.sv ====
module riscv_em_mem_stage
(
    input  logic                     i_riscv_em_clk,
    input  logic                     i_riscv_em_rst,
    input  logic                     i_riscv_em_en,          // High means stall.
    input  logic                     i_riscv_em_regw_e,
    input  riscv_em_pkg::resultsrc_t i_riscv_em_resultsrc_e,
    input  riscv_em_pkg::storesrc_t  i_riscv_em_storesrc_e,
    input  riscv_em_pkg::memext_t    i_riscv_em_memext_e,
    input  riscv_em_pkg::dword_t     i_riscv_em_pcplus4_e,
    input  riscv_em_pkg::dword_t     i_riscv_em_result_e,
    input  riscv_em_pkg::dword_t     i_riscv_em_storedata_e,
    input  riscv_em_pkg::dword_t     i_riscv_em_imm_e,
    input  riscv_em_pkg::regaddr_t   i_riscv_em_rdaddr_e,
    input  riscv_em_pkg::opcode_t    i_riscv_de_opcode_e,
    output logic                     o_riscv_em_regw_m,      // For writeback and forwarding.
    output riscv_em_pkg::regaddr_t   o_riscv_em_rdaddr_m,
    output riscv_em_pkg::dword_t     o_riscv_em_result_m,
    output riscv_em_pkg::dword_t     o_riscv_em_wbdata_m
);

    import riscv_em_pkg::*;

    resultsrc_t resultsrc_m;
    storesrc_t  storesrc_m;
    memext_t    memext_m;
    dword_t     pcplus4_m;
    dword_t     storedata_m;
    dword_t     imm_m;
    opcode_t    opcode_m;
    logic       memwe;
    byte_en_t   byte_en;
    dword_t     wdata;
    dmem_idx_t  dmem_idx;
    dword_t     rdata;

    riscv_em_ppreg u_riscv_em_ppreg
    (
        .i_riscv_em_clk         (i_riscv_em_clk),
        .i_riscv_em_rst         (i_riscv_em_rst),
        .i_riscv_em_en          (i_riscv_em_en),
        .i_riscv_em_regw_e      (i_riscv_em_regw_e),
        .i_riscv_em_resultsrc_e (i_riscv_em_resultsrc_e),
        .i_riscv_em_storesrc_e  (i_riscv_em_storesrc_e),
        .i_riscv_em_memext_e    (i_riscv_em_memext_e),
        .i_riscv_em_pcplus4_e   (i_riscv_em_pcplus4_e),
        .i_riscv_em_result_e    (i_riscv_em_result_e),
        .i_riscv_em_storedata_e (i_riscv_em_storedata_e),
        .i_riscv_em_imm_e       (i_riscv_em_imm_e),
        .i_riscv_em_rdaddr_e    (i_riscv_em_rdaddr_e),
        .i_riscv_de_opcode_e    (i_riscv_de_opcode_e),
        .o_riscv_em_regw_m      (o_riscv_em_regw_m),
        .o_riscv_em_resultsrc_m (resultsrc_m),
        .o_riscv_em_storesrc_m  (storesrc_m),
        .o_riscv_em_memext_m    (memext_m),
        .o_riscv_em_pcplus4_m   (pcplus4_m),
        .o_riscv_em_result_m    (o_riscv_em_result_m),
        .o_riscv_em_storedata_m (storedata_m),
        .o_riscv_em_imm_m       (imm_m),
        .o_riscv_em_rdaddr_m    (o_riscv_em_rdaddr_m),
        .o_riscv_de_opcode_m    (opcode_m)
    );

    riscv_em_store_align u_riscv_em_store_align
    (
        .i_riscv_em_opcode_m    (opcode_m),
        .i_riscv_em_storesrc_m  (storesrc_m),
        .i_riscv_em_addr_m      (o_riscv_em_result_m),
        .i_riscv_em_storedata_m (storedata_m),
        .o_riscv_em_memwe       (memwe),
        .o_riscv_em_byte_en     (byte_en),
        .o_riscv_em_wdata       (wdata)
    );

    // Upper address bits are dropped, so accesses wrap inside the memory.
    assign dmem_idx = o_riscv_em_result_m[10:3];

    riscv_em_dmem u_riscv_em_dmem
    (
        .i_riscv_em_clk     (i_riscv_em_clk),
        .i_riscv_em_memwe   (memwe),
        .i_riscv_em_byte_en (byte_en),
        .i_riscv_em_idx     (dmem_idx),
        .i_riscv_em_wdata   (wdata),
        .o_riscv_em_rdata   (rdata)
    );

    riscv_em_load_ext u_riscv_em_load_ext
    (
        .i_riscv_em_rdata       (rdata),
        .i_riscv_em_addr_m      (o_riscv_em_result_m),
        .i_riscv_em_pcplus4_m   (pcplus4_m),
        .i_riscv_em_imm_m       (imm_m),
        .i_riscv_em_memext_m    (memext_m),
        .i_riscv_em_resultsrc_m (resultsrc_m),
        .o_riscv_em_wbdata      (o_riscv_em_wbdata_m)
    );

endmodule

// ==== riscv_em_pkg.sv ====
package riscv_em_pkg;

    // Vector types that carry a meaning across the memory stage.
    typedef logic [63:0] dword_t;      // Data, address or immediate value.
    typedef logic [4:0]  regaddr_t;    // Destination register number.
    typedef logic [6:0]  opcode_t;     // Major opcode of the instruction.
    typedef logic [1:0]  resultsrc_t;  // Writeback source select.
    typedef logic [1:0]  storesrc_t;   // Store size.
    typedef logic [2:0]  memext_t;     // Load kind, same encoding as load funct3.
    typedef logic [7:0]  byte_en_t;    // One enable per byte lane.
    typedef logic [7:0]  dmem_idx_t;   // Doubleword index into the data memory.

    // Major opcode of the STORE group.
    localparam opcode_t OPCODE_STORE = 7'b0100011;

    // Writeback source codes.
    localparam resultsrc_t RESULT_ALU     = 2'd0;
    localparam resultsrc_t RESULT_LOAD    = 2'd1;
    localparam resultsrc_t RESULT_PCPLUS4 = 2'd2;
    localparam resultsrc_t RESULT_IMM     = 2'd3;

    // Store sizes, matching store funct3.
    localparam storesrc_t STORE_B = 2'd0;
    localparam storesrc_t STORE_H = 2'd1;
    localparam storesrc_t STORE_W = 2'd2;
    localparam storesrc_t STORE_D = 2'd3;

    // Load kinds, matching load funct3.
    localparam memext_t LOAD_B  = 3'd0;
    localparam memext_t LOAD_H  = 3'd1;
    localparam memext_t LOAD_W  = 3'd2;
    localparam memext_t LOAD_D  = 3'd3;
    localparam memext_t LOAD_BU = 3'd4;
    localparam memext_t LOAD_HU = 3'd5;
    localparam memext_t LOAD_WU = 3'd6;

    // Data memory size in doublewords.
    localparam int DMEM_DEPTH = 256;

endpackage

// ==== riscv_em_ppreg.sv ====
module riscv_em_ppreg
(
    input  logic                     i_riscv_em_clk,
    input  logic                     i_riscv_em_rst,
    input  logic                     i_riscv_em_en,          // High means stall.
    input  logic                     i_riscv_em_regw_e,
    input  riscv_em_pkg::resultsrc_t i_riscv_em_resultsrc_e,
    input  riscv_em_pkg::storesrc_t  i_riscv_em_storesrc_e,
    input  riscv_em_pkg::memext_t    i_riscv_em_memext_e,
    input  riscv_em_pkg::dword_t     i_riscv_em_pcplus4_e,
    input  riscv_em_pkg::dword_t     i_riscv_em_result_e,    // ALU result or memory address.
    input  riscv_em_pkg::dword_t     i_riscv_em_storedata_e,
    input  riscv_em_pkg::dword_t     i_riscv_em_imm_e,
    input  riscv_em_pkg::regaddr_t   i_riscv_em_rdaddr_e,
    input  riscv_em_pkg::opcode_t    i_riscv_de_opcode_e,
    output logic                     o_riscv_em_regw_m,
    output riscv_em_pkg::resultsrc_t o_riscv_em_resultsrc_m,
    output riscv_em_pkg::storesrc_t  o_riscv_em_storesrc_m,
    output riscv_em_pkg::memext_t    o_riscv_em_memext_m,
    output riscv_em_pkg::dword_t     o_riscv_em_pcplus4_m,
    output riscv_em_pkg::dword_t     o_riscv_em_result_m,
    output riscv_em_pkg::dword_t     o_riscv_em_storedata_m,
    output riscv_em_pkg::dword_t     o_riscv_em_imm_m,
    output riscv_em_pkg::regaddr_t   o_riscv_em_rdaddr_m,
    output riscv_em_pkg::opcode_t    o_riscv_de_opcode_m
);

    // A cleared register carries a bubble: no register write and no store.
    always_ff @(posedge i_riscv_em_clk or posedge i_riscv_em_rst)
    begin : em_ppreg_proc
        if (i_riscv_em_rst)
        begin
            o_riscv_em_regw_m      <= 1'b0;
            o_riscv_em_resultsrc_m <= '0;
            o_riscv_em_storesrc_m  <= '0;
            o_riscv_em_memext_m    <= '0;
            o_riscv_em_pcplus4_m   <= '0;
            o_riscv_em_result_m    <= '0;
            o_riscv_em_storedata_m <= '0;
            o_riscv_em_imm_m       <= '0;
            o_riscv_em_rdaddr_m    <= '0;
            o_riscv_de_opcode_m    <= '0;
        end
        else if (!i_riscv_em_en)                             // Stalled cycles keep the contents.
        begin
            o_riscv_em_regw_m      <= i_riscv_em_regw_e;
            o_riscv_em_resultsrc_m <= i_riscv_em_resultsrc_e;
            o_riscv_em_storesrc_m  <= i_riscv_em_storesrc_e;
            o_riscv_em_memext_m    <= i_riscv_em_memext_e;
            o_riscv_em_pcplus4_m   <= i_riscv_em_pcplus4_e;
            o_riscv_em_result_m    <= i_riscv_em_result_e;
            o_riscv_em_storedata_m <= i_riscv_em_storedata_e;
            o_riscv_em_imm_m       <= i_riscv_em_imm_e;
            o_riscv_em_rdaddr_m    <= i_riscv_em_rdaddr_e;
            o_riscv_de_opcode_m    <= i_riscv_de_opcode_e;
        end
    end

endmodule

// ==== riscv_em_store_align.sv ====
module riscv_em_store_align
(
    input  riscv_em_pkg::opcode_t   i_riscv_em_opcode_m,
    input  riscv_em_pkg::storesrc_t i_riscv_em_storesrc_m,
    input  riscv_em_pkg::dword_t    i_riscv_em_addr_m,
    input  riscv_em_pkg::dword_t    i_riscv_em_storedata_m,
    output logic                    o_riscv_em_memwe,
    output riscv_em_pkg::byte_en_t  o_riscv_em_byte_en,
    output riscv_em_pkg::dword_t    o_riscv_em_wdata
);

    import riscv_em_pkg::*;

    logic [2:0] byte_off;                   // Byte offset inside the doubleword.
    byte_en_t   size_mask;                  // Lanes covered by the store, from lane 0.

    assign byte_off = i_riscv_em_addr_m[2:0];

    // The opcode alone marks a store; no separate memory-write flag is carried.
    assign o_riscv_em_memwe = (i_riscv_em_opcode_m == OPCODE_STORE);

    always_comb
    begin
        case (i_riscv_em_storesrc_m)
            STORE_B: size_mask = 8'b0000_0001;
            STORE_H: size_mask = 8'b0000_0011;
            STORE_W: size_mask = 8'b0000_1111;
            STORE_D: size_mask = 8'b1111_1111;
            default: size_mask = 8'b0000_0000;
        endcase
    end

    // Naturally aligned accesses never push lanes past bit 7.
    assign o_riscv_em_byte_en = size_mask << byte_off;

    // Low bytes of the store data move up to the addressed lanes.
    assign o_riscv_em_wdata = i_riscv_em_storedata_m << {byte_off, 3'b000};

endmodule

// ==== riscv_em_tb.sv ====
module riscv_em_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import riscv_em_pkg::*;

    localparam opcode_t OP_LOAD = 7'b0000011;
    localparam opcode_t OP_ALU  = 7'b0110011;

    typedef struct packed
    {
        logic     regw;
        regaddr_t rdaddr;
        dword_t   result;
        dword_t   wbdata;
    } exp_t;

    logic        clk;
    logic        rst;
    logic        en;
    logic        regw_e;
    resultsrc_t  resultsrc_e;
    storesrc_t   storesrc_e;
    memext_t     memext_e;
    dword_t      pcplus4_e;
    dword_t      result_e;
    dword_t      storedata_e;
    dword_t      imm_e;
    regaddr_t    rdaddr_e;
    opcode_t     opcode_e;
    logic        regw_m;
    regaddr_t    rdaddr_m;
    dword_t      result_m;
    dword_t      wbdata_m;

    logic [7:0]  shadow [2048];     // Byte image of the memory, indexed by address bits 10:0.
    exp_t        exp_q [$];         // Expected outputs, pushed at the sampling edge.
    exp_t        cur_exp;
    logic        have_exp;
    logic [31:0] lfsr;
    int          err_cnt;
    int          check_cnt;
    int          tests_pass;
    int          tests_fail;
    int          test_err_start;

    riscv_em_mem_stage u_riscv_em_mem_stage
    (
        .i_riscv_em_clk         (clk),
        .i_riscv_em_rst         (rst),
        .i_riscv_em_en          (en),
        .i_riscv_em_regw_e      (regw_e),
        .i_riscv_em_resultsrc_e (resultsrc_e),
        .i_riscv_em_storesrc_e  (storesrc_e),
        .i_riscv_em_memext_e    (memext_e),
        .i_riscv_em_pcplus4_e   (pcplus4_e),
        .i_riscv_em_result_e    (result_e),
        .i_riscv_em_storedata_e (storedata_e),
        .i_riscv_em_imm_e       (imm_e),
        .i_riscv_em_rdaddr_e    (rdaddr_e),
        .i_riscv_de_opcode_e    (opcode_e),
        .o_riscv_em_regw_m      (regw_m),
        .o_riscv_em_rdaddr_m    (rdaddr_m),
        .o_riscv_em_result_m    (result_m),
        .o_riscv_em_wbdata_m    (wbdata_m)
    );

    always
    begin
        #2 clk = ~clk;
    end

    // Galois LFSR that steps once for each bit handed out.
    function automatic dword_t rand_bits(input int n);
        dword_t v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v    = {v[62:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0000_0000);
        end
        return v;
    endfunction

    // Random upper bits check that the memory wraps on its index bits.
    function automatic dword_t region_addr(input logic [10:0] low);
        dword_t hi;
        hi = rand_bits(53);
        return {hi[52:0], low};
    endfunction

    function automatic dword_t rand_addr(input int lg);
        dword_t r;
        r = (rand_bits(11) >> lg) << lg;    // Naturally aligned for 2**lg bytes.
        return region_addr(r[10:0]);
    endfunction

    // Little-endian gather; funct3 bit 2 marks the unsigned kinds.
    function automatic dword_t load_expect(input logic [10:0] addr, input memext_t kind);
        int     nbytes;
        dword_t val;
        nbytes = 1 << kind[1:0];
        val    = '0;
        for (int i = 0; i < nbytes; i++)
        begin
            val[i*8 +: 8] = shadow[addr + i];
        end
        if (!kind[2] && nbytes < 8 && val[nbytes*8 - 1])
        begin
            for (int i = nbytes; i < 8; i++)
            begin
                val[i*8 +: 8] = 8'hff;
            end
        end
        return val;
    endfunction

    // The model sees the inputs that the DUT samples at the same edge.
    always @(posedge clk)
    begin : model_proc
        exp_t e;
        if (rst)
        begin
            e = '0;
            exp_q.push_back(e);
        end
        else if (!en)
        begin
            e.regw   = regw_e;
            e.rdaddr = rdaddr_e;
            e.result = result_e;
            case (resultsrc_e)
                RESULT_LOAD:    e.wbdata = load_expect(result_e[10:0], memext_e);
                RESULT_PCPLUS4: e.wbdata = pcplus4_e;
                RESULT_IMM:     e.wbdata = imm_e;
                default:        e.wbdata = result_e;
            endcase
            exp_q.push_back(e);
            if (opcode_e == OPCODE_STORE)
            begin
                for (int i = 0; i < (1 << storesrc_e); i++)
                begin
                    shadow[result_e[10:0] + i] = storedata_e[i*8 +: 8];
                end
            end
        end
    end

    task automatic compare_out(input string name, input dword_t exp, input dword_t got);
        assert (got === exp)
        else
        begin
            $display("ERR %0t ns %s expected %h got %h", $time, name, exp, got);
            err_cnt++;
        end
    endtask

    // Stalled cycles push nothing, so the previous expectation must still hold.
    always @(negedge clk)
    begin : check_proc
        if (exp_q.size() > 0)
        begin
            cur_exp  = exp_q.pop_front();
            have_exp = 1'b1;
        end
        if (have_exp)
        begin
            compare_out("o_riscv_em_regw_m", {63'd0, cur_exp.regw}, {63'd0, regw_m});
            compare_out("o_riscv_em_rdaddr_m", {59'd0, cur_exp.rdaddr}, {59'd0, rdaddr_m});
            compare_out("o_riscv_em_result_m", cur_exp.result, result_m);
            compare_out("o_riscv_em_wbdata_m", cur_exp.wbdata, wbdata_m);
            check_cnt++;
        end
    end

    task automatic drive(input logic stall, input opcode_t op, input logic regw,
                         input resultsrc_t rs, input storesrc_t ss, input memext_t mx,
                         input dword_t res, input dword_t sd);
        dword_t rd;
        rd = rand_bits(5);
        @(posedge clk);
        en          <= stall;
        opcode_e    <= op;
        regw_e      <= regw;
        resultsrc_e <= rs;
        storesrc_e  <= ss;
        memext_e    <= mx;
        result_e    <= res;
        storedata_e <= sd;
        pcplus4_e   <= rand_bits(64);
        imm_e       <= rand_bits(64);
        rdaddr_e    <= rd[4:0];
    endtask

    task automatic do_store(input dword_t addr, input storesrc_t size, input dword_t data);
        drive(1'b0, OPCODE_STORE, 1'b0, RESULT_ALU, size, LOAD_D, addr, data);
    endtask

    task automatic do_load(input dword_t addr, input memext_t kind);
        drive(1'b0, OP_LOAD, 1'b1, RESULT_LOAD, STORE_D, kind, addr, rand_bits(64));
    endtask

    task automatic do_alu(input resultsrc_t rs);
        dword_t r;
        r = rand_bits(1);
        drive(1'b0, OP_ALU, r[0], rs, STORE_D, LOAD_D, rand_bits(64), rand_bits(64));
    endtask

    // Inputs change freely while stalled, a store opcode included.
    task automatic do_stall();
        dword_t r;
        r = rand_bits(8);
        drive(1'b1, r[0] ? OPCODE_STORE : OP_LOAD, r[1], r[3:2], r[5:4], {1'b0, r[7:6]},
              rand_bits(64), rand_bits(64));
    endtask

    task automatic wait_checks(input int n);
        int target;
        int waited;
        target = check_cnt + n;
        waited = 0;
        while (check_cnt < target && waited < 40)
        begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (check_cnt < target)
        begin
            $display("Timeout at %0t ns: the output checker stopped advancing.", $time);
            err_cnt++;
        end
    endtask

    task automatic finish_test(input string name);
        wait_checks(3);
        if (err_cnt == test_err_start)
        begin
            tests_pass++;
            $display("%0t ns  %s: ok", $time, name);
        end
        else
        begin
            tests_fail++;
            $display("%0t ns  %s: %0d errors", $time, name, err_cnt - test_err_start);
        end
        test_err_start = err_cnt;
    endtask

    initial
    begin : main_proc
        dword_t  r;
        dword_t  addr;
        dword_t  data;
        memext_t kind;
        int      nb;
        clk            = 1'b0;
        rst            = 1'b1;
        en             = 1'b0;
        regw_e         = 1'b0;
        resultsrc_e    = RESULT_ALU;
        storesrc_e     = STORE_B;
        memext_e       = LOAD_B;
        pcplus4_e      = '0;
        result_e       = '0;
        storedata_e    = '0;
        imm_e          = '0;
        rdaddr_e       = '0;
        opcode_e       = OP_ALU;
        lfsr           = 32'h04a9_1afc;
        have_exp       = 1'b0;
        err_cnt        = 0;
        check_cnt      = 0;
        tests_pass     = 0;
        tests_fail     = 0;
        test_err_start = 0;

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        finish_test("reset state");

        for (int t = 0; t < 24; t++)
        begin
            if (t % 3 == 0)
                do_alu(RESULT_ALU);
            else if (t % 3 == 1)
                do_alu(RESULT_PCPLUS4);
            else
                do_alu(RESULT_IMM);
        end
        finish_test("passthrough");

        for (int t = 0; t < DMEM_DEPTH; t++)
        begin
            do_store(region_addr({t[7:0], 3'b000}), STORE_D, rand_bits(64));  // Known contents.
        end
        for (int sz = 0; sz < 4; sz++)
        begin
            for (int off = 0; off < 8; off += (1 << sz))
            begin
                r = rand_bits(8);
                do_store(region_addr({r[7:0], off[2:0]}), storesrc_t'(sz), rand_bits(64));
                do_load(region_addr({r[7:0], 3'b000}), LOAD_D);
            end
        end
        finish_test("store sizes");

        for (int k = 0; k < 7; k++)
        begin
            nb = 1 << k[1:0];
            for (int off = 0; off < 8; off += nb)
            begin
                r    = rand_bits(8);
                addr = region_addr({r[7:0], off[2:0]});
                data = rand_bits(64);
                data[nb*8 - 1] = ((off / nb) % 2 == 0);      // Sign bit set and clear in turn.
                do_store(addr, storesrc_t'(k[1:0]), data);
                do_load(addr, memext_t'(k));
            end
        end
        finish_test("load extension");

        for (int t = 0; t < 9; t++)
        begin
            if (t % 3 == 0)
                do_load(rand_addr(3), LOAD_D);
            else if (t % 3 == 1)
                do_store(rand_addr(3), STORE_D, rand_bits(64));
            else
                do_alu(RESULT_IMM);
            r = rand_bits(2);
            repeat (2 + r[1:0]) do_stall();
        end
        do_alu(RESULT_ALU);
        finish_test("stall");

        for (int t = 0; t < 300; t++)
        begin
            r    = rand_bits(6);
            kind = (r[5:3] == 3'd7) ? LOAD_D : memext_t'(r[5:3]);
            case (r[2:0])
                3'd0, 3'd1: do_stall();
                3'd2, 3'd3: do_store(rand_addr(r[4:3]), storesrc_t'(r[4:3]), rand_bits(64));
                3'd4, 3'd5: do_load(rand_addr(kind[1:0]), kind);
                default:    do_alu((r[4:3] == RESULT_LOAD) ? RESULT_ALU : resultsrc_t'(r[4:3]));
            endcase
        end
        finish_test("random mix");

        $display("Tests: %0d passed, %0d failed; %0d output checks, %0d errors.",
                 tests_pass, tests_fail, check_cnt, err_cnt);
        if (tests_fail == 0 && err_cnt == 0)
        begin
            $display("*** TEST PASSED ***");
        end
        else
        begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
riscv_em_pkg.sv
riscv_em_ppreg.sv
riscv_em_store_align.sv
riscv_em_dmem.sv
riscv_em_load_ext.sv
riscv_em_mem_stage.sv
riscv_em_tb.sv
